// ==== verilog/rxlane_rst_pkg.sv ====
//////////////////////////////////////////////////
// rx lane reset sequencer shared definitions
// state enum, status/control structs, rate type
// cycle limits for the 25 MHz free-running clock
//////////////////////////////////////////////////
package rxlane_rst_pkg;

    typedef enum logic [3:0] {
        IDLE        = 4'd0,
        RXPD        = 4'd1,
        PMA_RST     = 4'd2,
        SIGNAL_WAIT = 4'd3,
        CDR_WAIT    = 4'd4,
        PCS_RST     = 4'd5,
        ALIGN_WAIT  = 4'd6,
        DONE        = 4'd7,
        CKDIV_ONLY  = 4'd8
    } rxlane_state_t;

    // pma/pcs status levels
    typedef struct packed {
        logic sigdet;
        logic cdr_align;
        logic word_align;
    } rxlane_status_t;

    // lane controls, all active high
    typedef struct packed {
        logic rx_lane_pd;
        logic rx_pma_rst;
        logic pcs_rx_rst;
    } rxlane_ctrl_t;

    typedef logic [2:0] rx_rate_t;   // clock divider code

    //////////////////////////////////////////////////
    // cycle limits
    //////////////////////////////////////////////////
    localparam int CLK_FREQ_MHZ      = 25;
    localparam int RXPD_CYCLES       = 2 * 40 * CLK_FREQ_MHZ;       // 80 us with margin
    localparam int PMA_RST_CYCLES    = 2 * CLK_FREQ_MHZ;            // 2 us
    localparam int CDR_WAIT_CYCLES   = 224 * CLK_FREQ_MHZ + 2048;   // worst case cdr lock
    localparam int PCS_RST_CYCLES    = 2 * 10 * CLK_FREQ_MHZ;       // 20 us
    localparam int ALIGN_WAIT_CYCLES = 1000;
    localparam int DONE_DLY_CYCLES   = 32;
    localparam int RATE_SET_CYCLES   = 3;
    localparam int RATE_DONE_CYCLES  = CLK_FREQ_MHZ / 5;
    localparam rx_rate_t RST_RATE    = 3'd0;

    localparam int TIMER_W    = $clog2(CDR_WAIT_CYCLES + 1);  // largest limit
    localparam int DONE_CNT_W = $clog2(DONE_DLY_CYCLES + 1);

endpackage

// ==== verilog/rxlane_rate_capture.sv ====
//////////////////////////////////////////////////
// rate change request capture
// synchronizer, rising edge detect, code latch
//////////////////////////////////////////////////
`timescale 1ns/100ps

module rxlane_rate_capture (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_rx_rate_chng,
    input  rxlane_rst_pkg::rx_rate_t      i_rxckdiv,
    input  rxlane_rst_pkg::rxlane_state_t i_state,
    output logic                          o_rate_req,
    output rxlane_rst_pkg::rx_rate_t      o_rate_sel
);
    import rxlane_rst_pkg::*;

    logic [2:0] chng_sync;     // [1:0] sync, [2] previous value
    rx_rate_t   ckdiv_q [2];   // code follows the request through the sync
    logic       chng_rise;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            chng_sync <= '0;
        else
            chng_sync <= {chng_sync[1:0], i_rx_rate_chng};
    end

    always_ff @(posedge clk)
    begin
        ckdiv_q[0] <= i_rxckdiv;
        ckdiv_q[1] <= ckdiv_q[0];
    end

    // edges inside the rate change itself are dropped
    assign chng_rise = chng_sync[1] & ~chng_sync[2] & (i_state != CKDIV_ONLY);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_rate_req <= 1'b0;
            o_rate_sel <= RST_RATE;
        end
        else if (i_state == CKDIV_ONLY)
            o_rate_req <= 1'b0;                 // taken by the sequencer
        else if (chng_rise)
        begin
            o_rate_req <= 1'b1;
            o_rate_sel <= ckdiv_q[1];
        end
    end

endmodule

// ==== verilog/rxlane_seq_fsm.sv ====
//////////////////////////////////////////////////
// rx lane sequencing FSM
// one shared state timer for holds and timeouts
//////////////////////////////////////////////////
`timescale 1ns/100ps

module rxlane_seq_fsm (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 i_rxlane_rst_n,
    input  rxlane_rst_pkg::rxlane_status_t       i_status,
    input  logic                                 i_rate_req,
    output rxlane_rst_pkg::rxlane_state_t        o_state,
    output logic [rxlane_rst_pkg::TIMER_W-1:0]   o_timer
);
    import rxlane_rst_pkg::*;

    rxlane_state_t next_state;
    logic          link_lost;    // any reason to go back to pma reset
    logic          timer_run;

    assign link_lost = ~i_status.sigdet | ~i_status.cdr_align | ~i_rxlane_rst_n;

    //////////////////////////////////////////////////
    // state register
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            o_state <= IDLE;
        else
            o_state <= next_state;
    end

    always_comb
    begin
        next_state = o_state;
        case (o_state)
            IDLE:
                next_state = RXPD;
            RXPD:
            begin
                if (o_timer == RXPD_CYCLES)
                    next_state = PMA_RST;
            end
            PMA_RST:
            begin
                // timer is held at zero while the lane reset request is low
                if (o_timer == PMA_RST_CYCLES)
                    next_state = SIGNAL_WAIT;
            end
            SIGNAL_WAIT:
            begin
                if (!i_rxlane_rst_n)
                    next_state = PMA_RST;
                else if (i_rate_req)
                    next_state = CKDIV_ONLY;
                else if (i_status.sigdet)
                    next_state = CDR_WAIT;
            end
            CDR_WAIT:
            begin
                if (!i_status.sigdet || !i_rxlane_rst_n || o_timer == CDR_WAIT_CYCLES)
                    next_state = PMA_RST;       // no lock in time
                else if (i_rate_req)
                    next_state = CKDIV_ONLY;
                else if (i_status.cdr_align)
                    next_state = PCS_RST;
            end
            PCS_RST:
            begin
                if (link_lost)
                    next_state = PMA_RST;
                else if (i_rate_req)
                    next_state = CKDIV_ONLY;
                else if (o_timer == PCS_RST_CYCLES)
                    next_state = ALIGN_WAIT;
            end
            ALIGN_WAIT:
            begin
                if (link_lost || o_timer == ALIGN_WAIT_CYCLES)
                    next_state = PMA_RST;
                else if (i_rate_req)
                    next_state = CKDIV_ONLY;
                else if (i_status.word_align)
                    next_state = DONE;
            end
            DONE:
            begin
                if (link_lost)
                    next_state = PMA_RST;
                else if (i_rate_req)
                    next_state = CKDIV_ONLY;
            end
            CKDIV_ONLY:
            begin
                if (!i_rxlane_rst_n)
                    next_state = PMA_RST;
                else if (o_timer == RATE_DONE_CYCLES)
                    next_state = SIGNAL_WAIT;   // resume with the new divider
            end
            default:
                next_state = IDLE;
        endcase
    end

    //////////////////////////////////////////////////
    // shared state timer
    //////////////////////////////////////////////////
    always_comb
    begin
        case (o_state)
            RXPD, CDR_WAIT, PCS_RST, ALIGN_WAIT, CKDIV_ONLY:
                timer_run = 1'b1;
            PMA_RST:
                timer_run = i_rxlane_rst_n;
            default:
                timer_run = 1'b0;               // no limit in this state
        endcase
    end

    // exits and timeouts all change state, so they clear here too
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            o_timer <= '0;
        else if (next_state != o_state || !timer_run)
            o_timer <= '0;
        else
            o_timer <= o_timer + 1'b1;
    end

endmodule

// ==== verilog/rxlane_rst_outputs.sv ====
//////////////////////////////////////////////////
// registered lane controls, rate code, done flags
// done delay counter
//////////////////////////////////////////////////
`timescale 1ns/100ps

module rxlane_rst_outputs (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  rxlane_rst_pkg::rxlane_state_t        i_state,
    input  logic [rxlane_rst_pkg::TIMER_W-1:0]   i_timer,
    input  rxlane_rst_pkg::rx_rate_t             i_rate_sel,
    output rxlane_rst_pkg::rxlane_ctrl_t         o_ctrl,
    output rxlane_rst_pkg::rx_rate_t             o_rx_rate,
    output logic                                 o_rxckdiv_done,
    output logic                                 o_rxlane_done
);
    import rxlane_rst_pkg::*;

    logic [DONE_CNT_W-1:0] dly_cnt;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_ctrl         <= '1;
            o_rx_rate      <= RST_RATE;
            o_rxckdiv_done <= 1'b0;
        end
        else
        begin
            case (i_state)
                RXPD:
                begin
                    if (i_timer == RXPD_CYCLES)
                        o_ctrl.rx_lane_pd <= 1'b0;      // stays low until reset
                end
                PMA_RST:
                begin
                    o_ctrl.rx_pma_rst <= (i_timer != PMA_RST_CYCLES);
                    o_ctrl.pcs_rx_rst <= 1'b1;
                    o_rxckdiv_done    <= 1'b0;
                end
                PCS_RST:
                    o_ctrl.pcs_rx_rst <= (i_timer < PCS_RST_CYCLES - 1);
                ALIGN_WAIT, DONE:
                    o_ctrl.pcs_rx_rst <= 1'b0;
                CKDIV_ONLY:
                begin
                    // pma held in reset while the divider changes
                    o_ctrl.rx_pma_rst <= (i_timer != RATE_DONE_CYCLES);
                    o_ctrl.pcs_rx_rst <= 1'b1;
                    o_rxckdiv_done    <= (i_timer == RATE_DONE_CYCLES);
                    if (i_timer == RATE_SET_CYCLES)
                        o_rx_rate <= i_rate_sel;
                end
                default:
                    o_ctrl.pcs_rx_rst <= 1'b1;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // done delay, restarts on each entry to DONE
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dly_cnt       <= '0;
            o_rxlane_done <= 1'b0;
        end
        else if (i_state != DONE)
        begin
            dly_cnt       <= '0;
            o_rxlane_done <= 1'b0;
        end
        else if (dly_cnt == DONE_DLY_CYCLES)
            o_rxlane_done <= 1'b1;
        else
            dly_cnt <= dly_cnt + 1'b1;
    end

endmodule

// ==== verilog/rxlane_rst_top.sv ====
//////////////////////////////////////////////////
// rx lane reset sequencer top level
//////////////////////////////////////////////////
`timescale 1ns/100ps

module rxlane_rst_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           i_rxlane_rst_n,    // lane reset request
    input  rxlane_rst_pkg::rxlane_status_t i_status,
    input  logic                           i_rx_rate_chng,
    input  rxlane_rst_pkg::rx_rate_t       i_rxckdiv,
    output rxlane_rst_pkg::rxlane_ctrl_t   o_ctrl,
    output rxlane_rst_pkg::rx_rate_t       o_rx_rate,
    output logic                           o_rxckdiv_done,
    output logic                           o_rxlane_done
);
    import rxlane_rst_pkg::*;

    logic                rate_req;
    rx_rate_t            rate_sel;
    rxlane_state_t       state;
    logic [TIMER_W-1:0]  timer;

    rxlane_rate_capture u_rate_capture (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_rx_rate_chng (i_rx_rate_chng),
        .i_rxckdiv      (i_rxckdiv),
        .i_state        (state),
        .o_rate_req     (rate_req),
        .o_rate_sel     (rate_sel)
    );

    rxlane_seq_fsm u_seq_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_rxlane_rst_n (i_rxlane_rst_n),
        .i_status       (i_status),
        .i_rate_req     (rate_req),
        .o_state        (state),
        .o_timer        (timer)
    );

    rxlane_rst_outputs u_rst_outputs (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_state        (state),
        .i_timer        (timer),
        .i_rate_sel     (rate_sel),
        .o_ctrl         (o_ctrl),
        .o_rx_rate      (o_rx_rate),
        .o_rxckdiv_done (o_rxckdiv_done),
        .o_rxlane_done  (o_rxlane_done)
    );

endmodule

// ==== sim/rxlane_rst_props.sv ====
//////////////////////////////////////////////////
// assertions on lane controls and done flag
// bound into the reset sequencer top level
//////////////////////////////////////////////////
`timescale 1ns/100ps

module rxlane_rst_props (
    input logic                         clk,
    input logic                         rst_n,
    input rxlane_rst_pkg::rxlane_ctrl_t i_ctrl,
    input logic                         i_rxlane_done
);
    import rxlane_rst_pkg::*;

    logic [DONE_CNT_W-1:0] since_pma_rst;   // saturates at the done delay

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            since_pma_rst <= '0;
        else if (i_ctrl.rx_pma_rst)
            since_pma_rst <= '0;
        else if (since_pma_rst != DONE_DLY_CYCLES)
            since_pma_rst <= since_pma_rst + 1'b1;
    end

    done_pcs_run: assert property (@(posedge clk) disable iff (!rst_n)
        i_rxlane_done |-> !i_ctrl.pcs_rx_rst)
        else $error("lane done while pcs reset is asserted");

    pcs_after_pma: assert property (@(posedge clk) disable iff (!rst_n)
        !i_ctrl.pcs_rx_rst |-> !i_ctrl.rx_pma_rst)
        else $error("pcs reset released while pma reset is asserted");

    done_delay: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(i_rxlane_done) |-> since_pma_rst == DONE_DLY_CYCLES)
        else $error("lane done rose too soon after pma reset");

endmodule

bind rxlane_rst_top rxlane_rst_props u_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_ctrl        (o_ctrl),
    .i_rxlane_done (o_rxlane_done)
);

// ==== sim/tb_rxlane_rst.sv ====
//////////////////////////////////////////////////
// directed testbench for the rx lane reset sequencer
// power up, recovery, rate change, timeouts
//////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_rxlane_rst;
    import rxlane_rst_pkg::*;

    localparam int SEQ_TAIL       = PCS_RST_CYCLES + DONE_DLY_CYCLES;  // cdr lock to done
    localparam int FULL_SEQ       = RXPD_CYCLES + PMA_RST_CYCLES + SEQ_TAIL;
    localparam int SLACK          = 24;     // single cycle states and registers
    localparam int TIMEOUT_CYCLES = 40000;  // about six times the whole run
    localparam rxlane_ctrl_t CTRL_ALL_ON   = '{1'b1, 1'b1, 1'b1};
    localparam rxlane_ctrl_t CTRL_RUN      = '{1'b0, 1'b0, 1'b0};
    localparam rxlane_ctrl_t CTRL_PMA_HOLD = '{1'b0, 1'b1, 1'b1};

    logic           clk;
    logic           rst_n;
    logic           i_rxlane_rst_n;
    rxlane_status_t i_status;
    logic           i_rx_rate_chng;
    rx_rate_t       i_rxckdiv;
    rxlane_ctrl_t   o_ctrl;
    rx_rate_t       o_rx_rate;
    logic           o_rxckdiv_done;
    logic           o_rxlane_done;

    int       checks = 0;
    int       errors = 0;
    int       cycle_cnt = 0;
    int       seed = 47381;
    rx_rate_t exp_rate = RST_RATE;   // last code applied to the pma

    rxlane_rst_top uut (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // compare and wait helpers
    //////////////////////////////////////////////////
    task automatic check_ctrl(input rxlane_ctrl_t exp);
        checks++;
        if (o_ctrl !== exp)
        begin
            errors++;
            $display("ERROR at %0t: o_ctrl expected %b, got %b", $time, exp, o_ctrl);
        end
    endtask

    task automatic check_rate(input rx_rate_t exp);
        checks++;
        if (o_rx_rate !== exp)
        begin
            errors++;
            $display("ERROR at %0t: o_rx_rate expected %0d, got %0d", $time, exp, o_rx_rate);
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("%0t: %s", $time, msg);
    endtask

    // counts cycles until lane done, both bounds checked
    task automatic wait_lane_done(input int lo, input int hi, input string label);
        int n;
        n = 0;
        while (!o_rxlane_done && n < hi)
        begin
            @(negedge clk);
            n++;
        end
        checks++;
        if (!o_rxlane_done)
            note_failure($sformatf("%s: lane done did not rise within %0d cycles", label, hi));
        else if (n < lo)
            note_failure($sformatf("%s: lane done rose after %0d cycles, before %0d",
                                   label, n, lo));
    endtask

    // done_low set when lane done must stay low for the whole wait
    task automatic wait_pma_reset(input int limit, input bit done_low, output int n);
        n = 0;
        while (!o_ctrl.rx_pma_rst && n < limit)
        begin
            @(negedge clk);
            n++;
            if (done_low && o_rxlane_done)
                note_failure("lane done high while waiting for pma reset");
        end
        checks++;
        if (!o_ctrl.rx_pma_rst)
            note_failure($sformatf("pma reset not reasserted within %0d cycles", limit));
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////
    task automatic test_reset();
        repeat (5) @(negedge clk);
        check_ctrl(CTRL_ALL_ON);
        check_rate(RST_RATE);
        check_flag("o_rxckdiv_done", o_rxckdiv_done, 1'b0);
        check_flag("o_rxlane_done", o_rxlane_done, 1'b0);
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_ctrl(CTRL_ALL_ON);
        check_flag("o_rxlane_done", o_rxlane_done, 1'b0);
    endtask

    task automatic test_power_up();
        wait_lane_done(FULL_SEQ, FULL_SEQ + SLACK, "power up");
        check_ctrl(CTRL_RUN);
        repeat (50)
        begin
            @(negedge clk);
            check_flag("o_rxlane_done", o_rxlane_done, 1'b1);
        end
    endtask

    task automatic test_sigdet_loss();
        int n;
        @(posedge clk);
        i_status.sigdet <= 1'b0;
        wait_pma_reset(3, 1'b0, n);
        check_flag("o_rxlane_done", o_rxlane_done, 1'b0);
        @(posedge clk);
        i_status.sigdet <= 1'b1;
        wait_lane_done(SEQ_TAIL, PMA_RST_CYCLES + SEQ_TAIL + SLACK, "sigdet restore");
    endtask

    task automatic test_rate_change();
        rx_rate_t code;
        int       n;
        code = rx_rate_t'($random(seed));
        if (code == exp_rate)
            code = code ^ 3'd1;             // make the change visible
        @(negedge clk);
        check_flag("o_rxckdiv_done", o_rxckdiv_done, 1'b0);
        @(posedge clk);
        i_rxckdiv      <= code;
        i_rx_rate_chng <= 1'b1;
        n = 0;
        while (!o_rxckdiv_done && n < 15)
        begin
            @(negedge clk);
            n++;
        end
        check_flag("o_rxckdiv_done", o_rxckdiv_done, 1'b1);
        exp_rate = code;
        check_rate(exp_rate);
        @(posedge clk);
        i_rx_rate_chng <= 1'b0;
        wait_lane_done(SEQ_TAIL, SEQ_TAIL + SLACK, "rate change");
        check_rate(exp_rate);
    endtask

    task automatic test_align_timeout();
        int n;
        // restart the sequence with alignment held off
        @(posedge clk);
        i_status.word_align <= 1'b0;
        i_status.sigdet     <= 1'b0;
        repeat (4) @(negedge clk);
        check_ctrl(CTRL_PMA_HOLD);
        @(posedge clk);
        i_status.sigdet <= 1'b1;
        n = 0;
        while (o_ctrl.pcs_rx_rst && n < PMA_RST_CYCLES + PCS_RST_CYCLES + SLACK)
        begin
            @(negedge clk);
            n++;
        end
        checks++;
        if (o_ctrl.pcs_rx_rst)
            note_failure("pcs reset was never released");
        wait_pma_reset(1600, 1'b1, n);
        checks++;
        if (n < ALIGN_WAIT_CYCLES)
            note_failure($sformatf("pma reset after %0d cycles, before align timeout", n));
        @(posedge clk);
        i_status.word_align <= 1'b1;
        wait_lane_done(SEQ_TAIL, PMA_RST_CYCLES + SEQ_TAIL + SLACK, "align restore");
    endtask

    task automatic test_lane_reset();
        @(posedge clk);
        i_rxlane_rst_n <= 1'b0;
        repeat (3) @(negedge clk);
        repeat (100)
        begin
            @(negedge clk);
            check_ctrl(CTRL_PMA_HOLD);
            check_flag("o_rxlane_done", o_rxlane_done, 1'b0);
        end
        @(posedge clk);
        i_rxlane_rst_n <= 1'b1;
        wait_lane_done(PMA_RST_CYCLES + SEQ_TAIL, PMA_RST_CYCLES + SEQ_TAIL + SLACK,
                       "lane reset release");
        check_ctrl(CTRL_RUN);
        check_rate(exp_rate);
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////
    initial
    begin
        rst_n          <= 1'b0;
        i_rxlane_rst_n <= 1'b1;
        i_status       <= '{1'b1, 1'b1, 1'b1};   // link already up
        i_rx_rate_chng <= 1'b0;
        i_rxckdiv      <= RST_RATE;
        test_reset();
        test_power_up();
        test_sigdet_loss();
        test_rate_change();
        test_align_timeout();
        test_lane_reset();
        $display("checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycle_cnt);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        while (cycle_cnt < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== rxlane_rst_top.f ====
verilog/rxlane_rst_pkg.sv
verilog/rxlane_rate_capture.sv
verilog/rxlane_seq_fsm.sv
verilog/rxlane_rst_outputs.sv
verilog/rxlane_rst_top.sv
sim/rxlane_rst_props.sv
sim/tb_rxlane_rst.sv

// ==== Makefile ====
# Verilator build and run for the rx lane reset sequencer

VERILATOR = verilator
TOP       = tb_rxlane_rst
FILELIST  = rxlane_rst_top.f
VFLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
